/* source/rs_settings.svh */
`ifndef RS_SETTINGS_SVH
`define RS_SETTINGS_SVH

// Number of reservation station entries
`define RS_DEPTH 8

// Operand and result width
`define RS_DATA_W 32

// Width of the destination and source tags
`define RS_TAG_W 5

// Number of common data bus ports
// Port 0 belongs to the ALU and port 1 is driven from outside
`define RS_CDB_N 2

`endif

/* source/rs_pkg.sv */
`include "rs_settings.svh"

package rs_pkg;

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_AND = 2'd2,
        OP_XOR = 2'd3
    } alu_op_t;

    // One source operand, data is only meaningful once rdy is set
    typedef struct packed {
        logic [`RS_TAG_W-1:0]  tag;
        logic [`RS_DATA_W-1:0] data;
        logic                  rdy;
    } src_t;

    typedef struct packed {
        alu_op_t              op;
        src_t                 src_a;
        src_t                 src_b;
        logic [`RS_TAG_W-1:0] dst_tag;
    } dispatch_t;

    typedef struct packed {
        alu_op_t               op;
        logic [`RS_DATA_W-1:0] src_a;
        logic [`RS_DATA_W-1:0] src_b;
        logic [`RS_TAG_W-1:0]  dst_tag;
    } issue_t;

    typedef struct packed {
        logic                  en;
        logic [`RS_TAG_W-1:0]  tag;
        logic [`RS_DATA_W-1:0] data;
    } cdb_t;

endpackage

/* source/rs_entry.sv */
`timescale 1ns/1ps
`include "rs_settings.svh"

module rs_entry (
    input  logic                          clk,
    input  logic                          i_arst_n,
    input  logic                          i_flush,
    input  logic                          i_reserve,
    input  logic                          i_dispatch_en,
    input  rs_pkg::dispatch_t             i_dispatch,
    input  rs_pkg::cdb_t                  i_cdb [`RS_CDB_N],
    input  logic                          i_issue_en,
    input  logic                          i_dispatching,
    input  logic                          i_issuing,
    input  logic [$clog2(`RS_DEPTH)-1:0]  i_issue_age,
    output logic                          o_empty,
    output logic                          o_ready,
    output logic [$clog2(`RS_DEPTH)-1:0]  o_age,
    output rs_pkg::issue_t                o_issue
);

    import rs_pkg::*;

    localparam int IDX_W = $clog2(`RS_DEPTH);

    logic                 occupied_q;
    logic                 reserved_q;
    logic [IDX_W-1:0]     age_q;
    logic                 age_inc;
    logic                 age_dec;
    alu_op_t              op_q;
    src_t                 src_a_q;
    src_t                 src_b_q;
    logic [`RS_TAG_W-1:0] dst_tag_q;
    src_t                 src_a_next;
    src_t                 src_b_next;

    // A waiting source takes the data of any enabled CDB port carrying its tag
    function automatic src_t snoop(input src_t src, input cdb_t cdb [`RS_CDB_N]);
        src_t result;
        result = src;
        for (int i = 0; i < `RS_CDB_N; i++) begin
            if (!src.rdy && cdb[i].en && (cdb[i].tag == src.tag)) begin
                result.data = cdb[i].data;
                result.rdy  = 1'b1;
            end
        end
        return result;
    endfunction

    // The dispatch payload is snooped too, so a broadcast in the write cycle is not missed
    assign src_a_next = snoop(i_dispatch_en ? i_dispatch.src_a : src_a_q, i_cdb);
    assign src_b_next = snoop(i_dispatch_en ? i_dispatch.src_b : src_b_q, i_cdb);

    // The age counts the occupied entries dispatched after this one
    // It shrinks when one of those younger entries leaves
    assign age_inc = i_dispatching & occupied_q;
    assign age_dec = i_issuing & occupied_q & (i_issue_age < age_q);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            occupied_q <= 1'b0;
            reserved_q <= 1'b0;
            age_q      <= '0;
        end else begin
            if (i_flush) begin
                occupied_q <= 1'b0;
                reserved_q <= 1'b0;
            end else begin
                if (i_reserve) begin
                    reserved_q <= 1'b1;
                end else if (i_dispatch_en) begin
                    reserved_q <= 1'b0;
                end
                if (i_dispatch_en) begin
                    occupied_q <= 1'b1;
                end else if (i_issue_en) begin
                    occupied_q <= 1'b0;
                end
            end
            if (i_dispatch_en) begin
                age_q <= '0;
            end else begin
                age_q <= age_q + age_inc - age_dec;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_dispatch_en) begin
            op_q      <= i_dispatch.op;
            dst_tag_q <= i_dispatch.dst_tag;
        end
        src_a_q <= src_a_next;
        src_b_q <= src_b_next;
    end

    assign o_empty = ~occupied_q & ~reserved_q;
    assign o_ready = occupied_q & src_a_q.rdy & src_b_q.rdy;
    assign o_age   = age_q;
    assign o_issue = '{op: op_q, src_a: src_a_q.data, src_b: src_b_q.data, dst_tag: dst_tag_q};

    // The station only writes entries it reserved from the empty set
    a_dispatch_free: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_dispatch_en |-> !occupied_q);

endmodule

/* source/rs_issue_select.sv */
`timescale 1ns/1ps
`include "rs_settings.svh"

module rs_issue_select (
    input  logic [`RS_DEPTH-1:0]          i_ready,
    input  logic [$clog2(`RS_DEPTH)-1:0]  i_age [`RS_DEPTH],
    input  logic                          i_stall,
    output logic [`RS_DEPTH-1:0]          o_select,
    output logic [$clog2(`RS_DEPTH)-1:0]  o_index
);

    localparam int IDX_W = $clog2(`RS_DEPTH);

    logic [`RS_DEPTH-1:0] age_mtx [`RS_DEPTH];
    logic [`RS_DEPTH-1:0] oldest;

    // Row i has bit j set when entry i is older than entry j
    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            for (int j = 0; j < `RS_DEPTH; j++) begin
                if (i == j) begin
                    age_mtx[i][j] = 1'b1;
                end else begin
                    age_mtx[i][j] = i_age[i] > i_age[j];
                end
            end
        end
    end

    // Comparisons against entries that cannot issue are ignored
    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            oldest[i] = &(age_mtx[i] | ~i_ready);
        end
    end

    assign o_select = oldest & i_ready & {`RS_DEPTH{~i_stall}};

    always_comb begin
        o_index = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (o_select[i]) begin
                o_index = o_index | IDX_W'(i);
            end
        end
    end

    // Occupied entries carry distinct ages, so at most one entry wins
    a_select_onehot: assert final ($onehot0(o_select));

endmodule

/* source/rs_station.sv */
`timescale 1ns/1ps
`include "rs_settings.svh"

module rs_station (
    input  logic              clk,
    input  logic              i_arst_n,
    input  logic              i_flush,
    input  logic              i_reserve_en,
    input  rs_pkg::dispatch_t i_dispatch,
    input  rs_pkg::cdb_t      i_cdb [`RS_CDB_N],
    input  logic              i_fu_stall,
    output logic              o_rs_stall,
    output logic              o_issue_valid,
    output rs_pkg::issue_t    o_issue
);

    import rs_pkg::*;

    localparam int IDX_W = $clog2(`RS_DEPTH);

    logic [`RS_DEPTH-1:0] entry_empty;
    logic [`RS_DEPTH-1:0] entry_ready;
    logic [IDX_W-1:0]     entry_age [`RS_DEPTH];
    issue_t               entry_issue [`RS_DEPTH];
    logic [`RS_DEPTH-1:0] reserve_sel;
    logic [`RS_DEPTH-1:0] dispatch_sel_q;
    logic [`RS_DEPTH-1:0] issue_sel;
    logic [IDX_W-1:0]     issue_idx;
    logic                 dispatching;
    logic                 issuing;
    logic                 issue_valid_q;
    issue_t               issue_q;

    for (genvar g = 0; g < `RS_DEPTH; g++) begin : g_entry
        rs_entry rs_entry_i (
            .clk           (clk),
            .i_arst_n      (i_arst_n),
            .i_flush       (i_flush),
            .i_reserve     (reserve_sel[g]),
            .i_dispatch_en (dispatch_sel_q[g]),
            .i_dispatch    (i_dispatch),
            .i_cdb         (i_cdb),
            .i_issue_en    (issue_sel[g]),
            .i_dispatching (dispatching),
            .i_issuing     (issuing),
            .i_issue_age   (entry_age[issue_idx]),
            .o_empty       (entry_empty[g]),
            .o_ready       (entry_ready[g]),
            .o_age         (entry_age[g]),
            .o_issue       (entry_issue[g])
        );
    end

    // Lowest empty entry, isolated as the lowest set bit of the empty vector
    assign reserve_sel = entry_empty & (~entry_empty + 1'b1) & {`RS_DEPTH{i_reserve_en}};

    // The payload follows the reserve by one cycle
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            dispatch_sel_q <= '0;
        end else if (i_flush) begin
            dispatch_sel_q <= '0;
        end else begin
            dispatch_sel_q <= reserve_sel;
        end
    end

    rs_issue_select rs_issue_select_i (
        .i_ready  (entry_ready),
        .i_age    (entry_age),
        .i_stall  (i_fu_stall),
        .o_select (issue_sel),
        .o_index  (issue_idx)
    );

    assign dispatching = |dispatch_sel_q;
    assign issuing     = |issue_sel;
    assign o_rs_stall  = ~|entry_empty;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            issue_valid_q <= 1'b0;
        end else if (i_flush) begin
            issue_valid_q <= 1'b0;
        end else if (!i_fu_stall) begin
            issue_valid_q <= issuing;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_fu_stall) begin
            issue_q <= entry_issue[issue_idx];
        end
    end

    assign o_issue_valid = issue_valid_q;
    assign o_issue       = issue_q;

    // The dispatcher must respect the stall level
    a_no_reserve_full: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_rs_stall |-> !i_reserve_en);

endmodule

/* source/rs_alu.sv */
`timescale 1ns/1ps
`include "rs_settings.svh"

module rs_alu (
    input  logic           clk,
    input  logic           i_arst_n,
    input  logic           i_flush,
    input  logic           i_hold,
    input  logic           i_issue_valid,
    input  rs_pkg::issue_t i_issue,
    output logic           o_stall,
    output rs_pkg::cdb_t   o_cdb
);

    import rs_pkg::*;

    logic                  accept;
    logic [`RS_DATA_W-1:0] result;
    logic                  pend_q;
    logic [`RS_DATA_W-1:0] result_q;
    logic [`RS_TAG_W-1:0]  tag_q;

    // Nothing new enters while the result register is frozen
    assign accept  = i_issue_valid & ~i_hold;
    assign o_stall = i_hold;

    always_comb begin
        case (i_issue.op)
            OP_ADD:  result = i_issue.src_a + i_issue.src_b;
            OP_SUB:  result = i_issue.src_a - i_issue.src_b;
            OP_AND:  result = i_issue.src_a & i_issue.src_b;
            OP_XOR:  result = i_issue.src_a ^ i_issue.src_b;
            default: result = '0;
        endcase
    end

    // A pending result waits out the hold and goes on the bus once it drops
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pend_q <= 1'b0;
        end else if (i_flush) begin
            pend_q <= 1'b0;
        end else if (!i_hold) begin
            pend_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            result_q <= result;
            tag_q    <= i_issue.dst_tag;
        end
    end

    assign o_cdb = '{en: pend_q & ~i_hold, tag: tag_q, data: result_q};

endmodule

/* source/rs_top.sv */
`timescale 1ns/1ps
`include "rs_settings.svh"

module rs_top (
    input  logic              clk,
    input  logic              i_arst_n,
    input  logic              i_flush,
    input  logic              i_reserve_en,
    input  rs_pkg::dispatch_t i_dispatch,
    input  rs_pkg::cdb_t      i_cdb_ext,
    input  logic              i_alu_hold,
    output logic              o_rs_stall,
    output rs_pkg::cdb_t      o_cdb_alu
);

    import rs_pkg::*;

    cdb_t   cdb [`RS_CDB_N];
    logic   issue_valid;
    issue_t issue;
    logic   fu_stall;

    // The ALU result feeds back on port 0 so dependents wake up from it
    assign cdb[0] = o_cdb_alu;
    assign cdb[1] = i_cdb_ext;

    rs_station rs_station_i (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_flush       (i_flush),
        .i_reserve_en  (i_reserve_en),
        .i_dispatch    (i_dispatch),
        .i_cdb         (cdb),
        .i_fu_stall    (fu_stall),
        .o_rs_stall    (o_rs_stall),
        .o_issue_valid (issue_valid),
        .o_issue       (issue)
    );

    rs_alu rs_alu_i (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_flush       (i_flush),
        .i_hold        (i_alu_hold),
        .i_issue_valid (issue_valid),
        .i_issue       (issue),
        .o_stall       (fu_stall),
        .o_cdb         (o_cdb_alu)
    );

endmodule

/* verif/tb_rs_top.sv */
`timescale 1ns/1ps
`include "rs_settings.svh"

module tb_rs_top;

    import rs_pkg::*;

    localparam int TAGS       = 2 ** `RS_TAG_W;
    // Tags from EXT_BASE upward belong to producers outside the core
    localparam int EXT_BASE   = 24;
    localparam int WAIT_LIMIT = 200;

    logic      clk;
    logic      arst_n;
    logic      flush;
    logic      reserve_en;
    dispatch_t dispatch;
    cdb_t      cdb_ext;
    logic      alu_hold;
    logic      rs_stall;
    cdb_t      cdb_alu;

    // Scoreboard state, indexed by destination tag
    logic                  live [TAGS];
    alu_op_t               op_m [TAGS];
    src_t                  a_m [TAGS];
    src_t                  b_m [TAGS];
    logic [`RS_DATA_W-1:0] done_val [TAGS];
    int                    seq_m [TAGS];
    int                    seq_cnt;
    int                    last_seq;
    int                    next_tag;
    int                    results;
    int                    errors;
    logic                  disp_mark;
    logic                  order_on;
    logic [31:0]           rng;
    logic                  exp_live;
    logic                  exp_ready;
    logic [`RS_DATA_W-1:0] exp_data;
    int                    exp_seq;

    rs_top rs_top_i (
        .clk          (clk),
        .i_arst_n     (arst_n),
        .i_flush      (flush),
        .i_reserve_en (reserve_en),
        .i_dispatch   (dispatch),
        .i_cdb_ext    (cdb_ext),
        .i_alu_hold   (alu_hold),
        .o_rs_stall   (rs_stall),
        .o_cdb_alu    (cdb_alu)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic logic [`RS_DATA_W-1:0] apply_op(input alu_op_t op,
                                                       input logic [`RS_DATA_W-1:0] a,
                                                       input logic [`RS_DATA_W-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a + ~b + 1'b1;
            OP_AND:  return a & b;
            default: return a ^ b;
        endcase
    endfunction

    // Negative selects a known random operand, a tag selects a producer
    function automatic src_t build_src(input int sel);
        src_t s;
        s = '0;
        if (sel < 0) begin
            s.rdy  = 1'b1;
            s.data = rand32();
        end else if (sel >= EXT_BASE || live[sel]) begin
            s.tag = `RS_TAG_W'(sel);
        end else begin
            s.rdy  = 1'b1;
            s.data = done_val[sel];
        end
        return s;
    endfunction

    function automatic int new_tag();
        do begin
            next_tag = (next_tag + 1) % EXT_BASE;
        end while (live[next_tag]);
        return next_tag;
    endfunction

    function automatic logic any_live();
        logic found;
        found = 1'b0;
        for (int t = 0; t < TAGS; t++) begin
            found = found | live[t];
        end
        return found;
    endfunction

    function automatic void wake(input logic [`RS_TAG_W-1:0] tag,
                                 input logic [`RS_DATA_W-1:0] data);
        for (int t = 0; t < TAGS; t++) begin
            if (live[t] && !a_m[t].rdy && a_m[t].tag == tag) begin
                a_m[t].data = data;
                a_m[t].rdy  = 1'b1;
            end
            if (live[t] && !b_m[t].rdy && b_m[t].tag == tag) begin
                b_m[t].data = data;
                b_m[t].rdy  = 1'b1;
            end
        end
    endfunction

    // Mid-cycle update, so every input and output of the cycle has settled
    always @(negedge clk) begin
        logic [`RS_DATA_W-1:0] alu_val;
        int                    t;
        if (arst_n) begin
            alu_val = apply_op(op_m[cdb_alu.tag], a_m[cdb_alu.tag].data, b_m[cdb_alu.tag].data);
            if (cdb_alu.en && live[cdb_alu.tag]) begin
                live[cdb_alu.tag]     = 1'b0;
                done_val[cdb_alu.tag] = alu_val;
                last_seq              = seq_m[cdb_alu.tag];
                results++;
            end
            if (disp_mark) begin
                t        = dispatch.dst_tag;
                live[t]  = 1'b1;
                op_m[t]  = dispatch.op;
                a_m[t]   = dispatch.src_a;
                b_m[t]   = dispatch.src_b;
                seq_m[t] = seq_cnt;
                seq_cnt++;
            end
            // A broadcast in the payload cycle reaches the new entry as well
            if (cdb_alu.en) begin
                wake(cdb_alu.tag, alu_val);
            end
            if (cdb_ext.en) begin
                wake(cdb_ext.tag, cdb_ext.data);
            end
            if (flush) begin
                for (int i = 0; i < TAGS; i++) begin
                    live[i] = 1'b0;
                end
            end
        end
    end

    always_comb begin
        exp_live  = live[cdb_alu.tag];
        exp_ready = a_m[cdb_alu.tag].rdy && b_m[cdb_alu.tag].rdy;
        exp_data  = apply_op(op_m[cdb_alu.tag], a_m[cdb_alu.tag].data, b_m[cdb_alu.tag].data);
        exp_seq   = seq_m[cdb_alu.tag];
    end

    a_result_tag: assert property (@(negedge clk) disable iff (!arst_n)
        cdb_alu.en |-> exp_live)
        else begin
            errors++;
            $display("ALU result at %0t carries tag %0d, which is not outstanding",
                     $time, $sampled(cdb_alu.tag));
        end

    a_result_wait: assert property (@(negedge clk) disable iff (!arst_n)
        cdb_alu.en && exp_live |-> exp_ready)
        else begin
            errors++;
            $display("ALU result for tag %0d at %0t went out before its sources arrived",
                     $sampled(cdb_alu.tag), $time);
        end

    a_result_data: assert property (@(negedge clk) disable iff (!arst_n)
        cdb_alu.en && exp_live && exp_ready |-> cdb_alu.data == exp_data)
        else begin
            errors++;
            $display("ERROR %0t: o_cdb_alu.data got %h expected %h",
                     $time, $sampled(cdb_alu.data), $sampled(exp_data));
        end

    a_hold_quiet: assert property (@(negedge clk) disable iff (!arst_n)
        alu_hold |-> !cdb_alu.en)
        else begin
            errors++;
            $display("ALU broadcast at %0t while the hold was high", $time);
        end

    a_age_order: assert property (@(negedge clk) disable iff (!arst_n)
        order_on && cdb_alu.en && exp_live |-> exp_seq > last_seq)
        else begin
            errors++;
            $display("ALU result for tag %0d at %0t overtook an older instruction",
                     $sampled(cdb_alu.tag), $time);
        end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) tick();
    endtask

    task automatic stop_on_timeout(input string what);
        errors++;
        $display("Timed out at %0t waiting for %s", $time, what);
        $display("Results checked: %0d, errors: %0d", results, errors);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic expect_level(input string name, input logic got, input logic exp);
        assert (got === exp)
        else begin
            errors++;
            $display("ERROR %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic wait_free();
        int n;
        n = 0;
        while (rs_stall && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (rs_stall) begin
            stop_on_timeout("a free station entry");
        end
    endtask

    task automatic wait_retired(input int tag);
        int n;
        n = 0;
        while (live[tag] && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (live[tag]) begin
            stop_on_timeout("an ALU result");
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (any_live() && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (any_live()) begin
            stop_on_timeout("the outstanding results");
        end
    endtask

    task automatic ext_pulse(input int tag);
        cdb_ext = '{en: 1'b1, tag: `RS_TAG_W'(tag), data: rand32()};
        tick();
        cdb_ext.en = 1'b0;
    endtask

    // Reserve strobe in one cycle, payload in the next
    task automatic send_op(input int a_sel, input int b_sel, input int ext_tag,
                           output int dst);
        logic [31:0] r;
        wait_free();
        dst        = new_tag();
        reserve_en = 1'b1;
        tick();
        reserve_en       = 1'b0;
        r                = rand32();
        dispatch.op      = alu_op_t'(r[1:0]);
        dispatch.src_a   = build_src(a_sel);
        dispatch.src_b   = build_src(b_sel);
        dispatch.dst_tag = `RS_TAG_W'(dst);
        disp_mark        = 1'b1;
        if (ext_tag >= 0) begin
            cdb_ext = '{en: 1'b1, tag: `RS_TAG_W'(ext_tag), data: rand32()};
        end
        tick();
        disp_mark  = 1'b0;
        cdb_ext.en = 1'b0;
    endtask

    initial begin
        int tag_x;
        int tag_p;
        int tag_d;
        arst_n     = 1'b0;
        flush      = 1'b0;
        reserve_en = 1'b0;
        dispatch   = '0;
        cdb_ext    = '0;
        alu_hold   = 1'b0;
        disp_mark  = 1'b0;
        order_on   = 1'b0;
        rng        = 32'hc3f2a7bf;
        next_tag   = 0;
        seq_cnt    = 0;
        last_seq   = -1;
        results    = 0;
        errors     = 0;
        for (int t = 0; t < TAGS; t++) begin
            live[t]     = 1'b0;
            op_m[t]     = OP_ADD;
            a_m[t]      = '0;
            b_m[t]      = '0;
            done_val[t] = '0;
            seq_m[t]    = 0;
        end
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;

        for (int i = 0; i < 12; i++) begin
            send_op(-1, -1, -1, tag_x);
        end
        drain();

        // Wakeup from the external port, later and in the payload cycle
        send_op(EXT_BASE + 1, -1, -1, tag_x);
        idle(6);
        ext_pulse(EXT_BASE + 1);
        wait_retired(tag_x);
        send_op(-1, EXT_BASE + 2, EXT_BASE + 2, tag_x);
        wait_retired(tag_x);
        send_op(EXT_BASE + 3, EXT_BASE + 4, -1, tag_x);
        idle(3);
        ext_pulse(EXT_BASE + 4);
        idle(3);
        ext_pulse(EXT_BASE + 3);
        wait_retired(tag_x);

        // Chain of dependents fed back through CDB port 0
        send_op(-1, -1, -1, tag_p);
        send_op(tag_p, -1, -1, tag_d);
        send_op(tag_d, tag_p, -1, tag_x);
        drain();

        // Held ALU lets the station fill up, then results leave oldest first
        // The first result already sits in the ALU when the hold rises
        send_op(-1, -1, -1, tag_x);
        idle(2);
        alu_hold = 1'b1;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            send_op(-1, -1, -1, tag_x);
        end
        expect_level("o_rs_stall", rs_stall, 1'b1);
        idle(4);
        order_on = 1'b1;
        alu_hold = 1'b0;
        wait_free();
        drain();
        order_on = 1'b0;

        // Flush a full station holding waiting entries and an issue on its way to the ALU
        send_op(EXT_BASE + 5, -1, -1, tag_x);
        send_op(-1, EXT_BASE + 5, -1, tag_x);
        for (int i = 2; i < `RS_DEPTH - 1; i++) begin
            send_op(EXT_BASE + 5, -1, -1, tag_x);
        end
        send_op(-1, -1, -1, tag_x);
        expect_level("o_rs_stall", rs_stall, 1'b1);
        flush = 1'b1;
        tick();
        flush = 1'b0;
        expect_level("o_rs_stall", rs_stall, 1'b0);
        idle(8);
        ext_pulse(EXT_BASE + 5);
        idle(8);
        for (int i = 0; i < 4; i++) begin
            send_op(-1, -1, -1, tag_x);
        end
        drain();

        $display("Results checked: %0d, errors: %0d", results, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+source
source/rs_pkg.sv
source/rs_entry.sv
source/rs_issue_select.sv
source/rs_station.sv
source/rs_alu.sv
source/rs_top.sv
verif/tb_rs_top.sv
